/* hw/rvPipePkg.sv */
package rvPipePkg;

    typedef logic [4:0]  regAddrT;
    typedef logic [31:0] wordT;
    typedef logic [13:0] pcT;                       // Byte address into instruction memory
    typedef logic [6:0]  opcodeT;

    // ##################################################
    // Opcodes
    // ##################################################
    localparam opcodeT opcLui    = 7'b0110111;
    localparam opcodeT opcAuipc  = 7'b0010111;
    localparam opcodeT opcJal    = 7'b1101111;
    localparam opcodeT opcJalr   = 7'b1100111;
    localparam opcodeT opcBranch = 7'b1100011;
    localparam opcodeT opcLoad   = 7'b0000011;
    localparam opcodeT opcStore  = 7'b0100011;
    localparam opcodeT opcAriI   = 7'b0010011;
    localparam opcodeT opcAriR   = 7'b0110011;

    localparam int dramDepth = 256;                 // Words
    typedef logic [$clog2(dramDepth)-1:0] dramAddrT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB                                    // LUI
    } aluOpT;

    typedef struct packed {
        opcodeT     opcode;
        regAddrT    rd;
        regAddrT    rs1;
        regAddrT    rs2;
        wordT       imm;
        aluOpT      aluOp;
        logic       srcAIsPc;
        logic       srcBIsImm;
        logic       regWe;
        logic       isLoad;
        logic       isStore;
        logic       isBranch;
        logic       isJump;                         // JAL and JALR
        logic       isJalr;
        logic [2:0] funct3;                         // Branch condition
    } decodedT;

    typedef struct packed {
        logic    valid;
        pcT      pc;
        decodedT dec;
    } xStageT;

    typedef struct packed {
        logic    valid;
        pcT      pc;
        opcodeT  opcode;
        regAddrT rd;
        logic    regWe;
        logic    isLoad;
        wordT    aluResult;                         // Link value for jumps
    } wStageT;

    typedef struct packed {
        logic    valid;
        pcT      pc;
        regAddrT rd;
        wordT    data;
    } retireT;

endpackage

/* hw/hazardUnit.sv */
module hazardUnit (
    input  rvPipePkg::opcodeT  xOpcode,
    input  rvPipePkg::regAddrT xRs1,
    input  rvPipePkg::regAddrT xRs2,
    input  logic               xValid,
    input  rvPipePkg::opcodeT  wOpcode,
    input  rvPipePkg::regAddrT wRd,
    input  logic               wValid,
    input  logic               wRegWe,
    input  logic               diverge,
    output logic               forwardA,
    output logic               forwardB,
    output logic               stall,
    output logic               squash
);
    import rvPipePkg::*;

    logic wLive;
    logic hitA;
    logic hitB;
    logic redirect;

    // W will write a real register this cycle
    assign wLive = wValid && wRegWe && (wRd != '0);
    assign hitA  = wLive && (wRd == xRs1);
    assign hitB  = wLive && (wRd == xRs2);

    // ##################################################
    // Data hazards from W
    // ##################################################
    always_comb begin
        forwardA = 1'b0;
        forwardB = 1'b0;
        stall    = 1'b0;
        case (wOpcode)
            opcLoad: begin
                stall = xValid && (hitA || hitB);   // RAM data too late to forward
            end
            default: begin
                forwardA = hitA;
                forwardB = hitB;
            end
        endcase
    end

    // ##################################################
    // Control flow in X
    // ##################################################
    always_comb begin
        case (xOpcode)
            opcJal, opcJalr: begin
                redirect = 1'b1;
            end
            opcBranch: begin
                redirect = diverge;
            end
            default: begin
                redirect = 1'b0;
            end
        endcase
    end

    // A stalled X has stale operands, so its outcome is not final yet
    assign squash = xValid && redirect && !stall;

endmodule

/* hw/instDecoder.sv */
module instDecoder (
    input  rvPipePkg::wordT    instr,
    output rvPipePkg::decodedT dec
);
    import rvPipePkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    wordT       immI;
    wordT       immS;
    wordT       immB;
    wordT       immU;
    wordT       immJ;

    function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Unused register fields stay zero so they never match in hazard checks
    always_comb begin
        dec           = '0;
        dec.opcode    = opcode;
        dec.funct3    = funct3;
        dec.srcBIsImm = (opcode != opcAriR);
        case (opcode)
            opcLui: begin
                dec.rd    = instr[11:7];
                dec.imm   = immU;
                dec.aluOp = aluPassB;
                dec.regWe = 1'b1;
            end
            opcAuipc, opcJal: begin
                dec.rd       = instr[11:7];
                dec.imm      = (opcode == opcJal) ? immJ : immU;
                dec.srcAIsPc = 1'b1;
                dec.regWe    = 1'b1;
                dec.isJump   = (opcode == opcJal);
            end
            opcJalr, opcLoad: begin
                dec.rd     = instr[11:7];
                dec.rs1    = instr[19:15];
                dec.imm    = immI;
                dec.regWe  = 1'b1;
                dec.isJump = (opcode == opcJalr);
                dec.isJalr = (opcode == opcJalr);
                dec.isLoad = (opcode == opcLoad);   // Any width treated as a word
            end
            opcBranch, opcStore: begin
                dec.rs1      = instr[19:15];
                dec.rs2      = instr[24:20];
                dec.imm      = (opcode == opcBranch) ? immB : immS;
                dec.srcAIsPc = (opcode == opcBranch); // ALU forms the branch target
                dec.isBranch = (opcode == opcBranch);
                dec.isStore  = (opcode == opcStore);
            end
            opcAriI: begin
                dec.rd    = instr[11:7];
                dec.rs1   = instr[19:15];
                dec.imm   = immI;
                dec.aluOp = aluFromFunct(funct3, (funct3 == 3'b101) && instr[30]);
                dec.regWe = 1'b1;
            end
            opcAriR: begin
                dec.rd    = instr[11:7];
                dec.rs1   = instr[19:15];
                dec.rs2   = instr[24:20];
                dec.aluOp = aluFromFunct(funct3, instr[30]);
                dec.regWe = 1'b1;
            end
            default: begin
                dec.srcBIsImm = 1'b0;                // Unsupported opcode runs as a no-op
            end
        endcase
    end

endmodule

/* hw/aluUnit.sv */
module aluUnit (
    input  rvPipePkg::aluOpT aluOp,
    input  rvPipePkg::wordT  a,
    input  rvPipePkg::wordT  b,
    input  logic [2:0]       funct3,
    input  rvPipePkg::wordT  rs1Val,
    input  rvPipePkg::wordT  rs2Val,
    output rvPipePkg::wordT  result,
    output logic             diverge
);
    import rvPipePkg::*;

    logic [4:0] shamt;
    logic       isEq;
    logic       isLt;
    logic       isLtu;

    assign shamt = b[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSlt:   result = wordT'($signed(a) < $signed(b));
            aluSltu:  result = wordT'(a < b);
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSra:   result = wordT'($signed(a) >>> shamt);
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    // Branch compare on the register operands, independent of the adder
    assign isEq  = (rs1Val == rs2Val);
    assign isLt  = ($signed(rs1Val) < $signed(rs2Val));
    assign isLtu = (rs1Val < rs2Val);

    always_comb begin
        case (funct3)
            3'b000:  diverge = isEq;                // BEQ
            3'b001:  diverge = !isEq;
            3'b100:  diverge = isLt;
            3'b101:  diverge = !isLt;
            3'b110:  diverge = isLtu;
            3'b111:  diverge = !isLtu;              // BGEU
            default: diverge = 1'b0;
        endcase
    end

endmodule

/* hw/regFile.sv */
module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  rvPipePkg::regAddrT raddrA,
    input  rvPipePkg::regAddrT raddrB,
    input  logic               we,
    input  rvPipePkg::regAddrT waddr,
    input  rvPipePkg::wordT    wdata,
    output rvPipePkg::wordT    rdataA,
    output rvPipePkg::wordT    rdataB
);
    import rvPipePkg::*;

    wordT regs [1:31];                              // x0 is not stored

    function automatic wordT readPort(input regAddrT addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && (waddr == addr)) begin
            return wdata;                           // Write-through from W
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdataA = readPort(raddrA);
    assign rdataB = readPort(raddrB);

endmodule

/* hw/dataRam.sv */
module dataRam (
    input  logic                clk,
    input  logic                we,
    input  rvPipePkg::dramAddrT addr,
    input  rvPipePkg::wordT     wdata,
    output rvPipePkg::wordT     rdata
);
    import rvPipePkg::*;

    wordT mem [dramDepth];

    // Address sampled while the access is in X, data out during W
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* hw/pipeCore.sv */
module pipeCore (
    input  logic              clk,
    input  logic              rstN,
    input  rvPipePkg::wordT   imemData,
    output rvPipePkg::pcT     imemAddr,
    output rvPipePkg::retireT retire
);
    import rvPipePkg::*;

    pcT       pc;
    pcT       target;
    decodedT  dDec;
    wordT     dRs1Val;
    wordT     dRs2Val;
    xStageT   xStage;
    wordT     rs1Val;
    wordT     rs2Val;
    wStageT   wStage;
    wordT     opA;
    wordT     opB;
    wordT     aluA;
    wordT     aluB;
    wordT     aluOut;
    wordT     xResult;
    dramAddrT ramAddr;
    wordT     ramRdata;
    wordT     wData;
    logic     wWe;
    logic     ramWe;
    logic     diverge;
    logic     branchTaken;
    logic     forwardA;
    logic     forwardB;
    logic     stall;
    logic     squash;

    // ##################################################
    // D stage
    // ##################################################
    assign imemAddr = pc;

    instDecoder uDecoder (
        .instr (imemData),
        .dec   (dDec)
    );

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .raddrA (dDec.rs1),
        .raddrB (dDec.rs2),
        .we     (wWe),
        .waddr  (wStage.rd),
        .wdata  (wData),
        .rdataA (dRs1Val),
        .rdataB (dRs2Val)
    );

    // ##################################################
    // X stage
    // ##################################################
    assign opA  = forwardA ? wData : rs1Val;
    assign opB  = forwardB ? wData : rs2Val;
    assign aluA = xStage.dec.srcAIsPc ? wordT'(xStage.pc) : opA;
    assign aluB = xStage.dec.srcBIsImm ? xStage.dec.imm : opB;

    aluUnit uAlu (
        .aluOp   (xStage.dec.aluOp),
        .a       (aluA),
        .b       (aluB),
        .funct3  (xStage.dec.funct3),
        .rs1Val  (opA),
        .rs2Val  (opB),
        .result  (aluOut),
        .diverge (diverge)
    );

    assign branchTaken = xStage.valid && xStage.dec.isBranch && diverge;
    assign target      = {aluOut[13:1], aluOut[0] & ~xStage.dec.isJalr};
    assign xResult     = xStage.dec.isJump ? wordT'(xStage.pc) + 32'd4 : aluOut;
    assign ramAddr     = dramAddrT'(aluOut >> 2);
    assign ramWe       = xStage.valid && xStage.dec.isStore && !stall; // Rewritten after stall

    dataRam uDataRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (opB),
        .rdata (ramRdata)
    );

    hazardUnit uHazard (
        .xOpcode  (xStage.dec.opcode),
        .xRs1     (xStage.dec.rs1),
        .xRs2     (xStage.dec.rs2),
        .xValid   (xStage.valid),
        .wOpcode  (wStage.opcode),
        .wRd      (wStage.rd),
        .wValid   (wStage.valid),
        .wRegWe   (wStage.regWe),
        .diverge  (branchTaken),
        .forwardA (forwardA),
        .forwardB (forwardB),
        .stall    (stall),
        .squash   (squash)
    );

    // ##################################################
    // W stage
    // ##################################################
    assign wWe   = wStage.valid && wStage.regWe;
    assign wData = wStage.isLoad ? ramRdata : wStage.aluResult;

    assign retire.valid = wWe && (wStage.rd != '0);
    assign retire.pc    = wStage.pc;
    assign retire.rd    = wStage.rd;
    assign retire.data  = wData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc           <= '0;
            xStage.valid <= 1'b0;
            wStage.valid <= 1'b0;
        end else if (stall) begin
            wStage.valid <= 1'b0;                   // Bubble behind the held X
            // Pick up the load result that X is waiting on
            if (wStage.rd == xStage.dec.rs1) begin
                rs1Val <= wData;
            end
            if (wStage.rd == xStage.dec.rs2) begin
                rs2Val <= wData;
            end
        end else begin
            pc               <= squash ? target : pc + pcT'(4);
            xStage.valid     <= !squash;            // Drop the slot behind a redirect
            xStage.pc        <= pc;
            xStage.dec       <= dDec;
            rs1Val           <= dRs1Val;
            rs2Val           <= dRs2Val;
            wStage.valid     <= xStage.valid;
            wStage.pc        <= xStage.pc;
            wStage.opcode    <= xStage.dec.opcode;
            wStage.rd        <= xStage.dec.rd;
            wStage.regWe     <= xStage.dec.regWe;
            wStage.isLoad    <= xStage.dec.isLoad;
            wStage.aluResult <= xResult;
        end
    end

    // ##################################################
    // Assertions
    // ##################################################

    // The bubble put into W on a stall must clear the load-use hazard
    assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall);

    assert property (@(posedge clk) disable iff (!rstN)
        (xStage.valid && !$isunknown(xStage.dec.aluOp)) |-> !$isunknown(aluOut));

endmodule

/* test/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// ##################################################
// Architectural model, one instruction per step
// ##################################################
function automatic wordT computeAlu(input logic [2:0] f3, input logic alt, input wordT a,
                                    input wordT b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchHolds(input logic [2:0] f3, input wordT a, input wordT b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Runs the program image and lists every write to a nonzero register in order
task automatic buildExpected();
    wordT xr [32];
    wordT dmem [dramDepth];
    wordT ins;
    wordT rs1v;
    wordT rs2v;
    wordT immI;
    wordT res;
    pcT   pc;
    pcT   nextPc;
    logic wr;
    int   steps;
    for (int i = 0; i < 32; i++) begin
        xr[i] = '0;
    end
    pc = '0;
    steps = 0;
    expTotal = 0;
    while (pc != endPc && steps < 4096) begin
        ins    = imem[pc[13:2]];
        rs1v   = xr[ins[19:15]];
        rs2v   = xr[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        nextPc = pc + pcT'(4);
        res    = wordT'(pc) + 32'd4;                // Link value for jumps
        wr     = 1'b1;
        case (opcodeT'(ins[6:0]))
            opcLui:   res = {ins[31:12], 12'b0};
            opcAuipc: res = wordT'(pc) + {ins[31:12], 12'b0};
            opcJal:   nextPc = pc + pcT'({{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0});
            opcJalr:  nextPc = pcT'((rs1v + immI) & ~32'd1);
            opcBranch: begin
                wr = 1'b0;
                if (branchHolds(ins[14:12], rs1v, rs2v)) begin
                    nextPc = pc + pcT'({{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0});
                end
            end
            opcLoad:  res = dmem[dramAddrT'((rs1v + immI) >> 2)];
            opcStore: begin
                wr = 1'b0;
                dmem[dramAddrT'((rs1v + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2)] = rs2v;
            end
            opcAriI:  res = computeAlu(ins[14:12], (ins[14:12] == 3'b101) && ins[30], rs1v, immI);
            opcAriR:  res = computeAlu(ins[14:12], ins[30], rs1v, rs2v);
            default:  wr = 1'b0;
        endcase
        if (wr && (ins[11:7] != 5'd0)) begin
            xr[ins[11:7]] = res;
            expList[expTotal] = '{1'b1, pc, ins[11:7], res};
            expTotal++;
            expEnd[testIndex(pc)] = expTotal;
        end
        pc = nextPc;
        steps++;
    end
endtask

`endif

/* test/tbPipeCore.sv */
module tbPipeCore;
    import rvPipePkg::*;

    localparam int maxRetire = 512;
    localparam int testCount = 5;

    logic   clk = 1'b0;
    logic   rstN;
    wordT   imemData;
    pcT     imemAddr;
    retireT retire;

    wordT   imem [4096];
    int     progLen;
    pcT     endPc;
    pcT     testStart [testCount];
    string  testNames [testCount] = '{"forwarding", "load-use", "branches", "jumps", "random ALU"};
    retireT expList [maxRetire];
    int     expEnd [testCount] = '{default: 0};
    int     testErrors [testCount] = '{default: 0};
    int     expTotal;
    int     expIdx;
    retireT expHead;
    int     errorCount = 0;
    int     passCount = 0;
    int     failCount = 0;
    int     curTest = 0;
    int     cycleCount = 0;
    int     cycleLimit;

    pipeCore u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .retire   (retire)
    );

    always #50 clk = ~clk;

    assign imemData = imem[imemAddr[13:2]];         // Combinational instruction memory

    // ##################################################
    // Instruction encoding
    // ##################################################
    function automatic wordT rType(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                                   input logic [2:0] f3, input regAddrT rd);
        return {f7, rs2, rs1, f3, rd, opcAriR};
    endfunction

    function automatic wordT iType(input int imm, input regAddrT rs1, input logic [2:0] f3,
                                   input regAddrT rd, input opcodeT opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic wordT sType(input int imm, input regAddrT rs2, input regAddrT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcStore};
    endfunction

    function automatic wordT bType(input int imm, input regAddrT rs2, input regAddrT rs1,
                                   input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
    endfunction

    function automatic wordT uType(input int imm20, input regAddrT rd, input opcodeT opc);
        return {imm20[19:0], rd, opc};
    endfunction

    function automatic wordT jType(input int imm, input regAddrT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
    endfunction

    task automatic putInstr(input wordT w);
        imem[progLen] = w;
        progLen++;
    endtask

    function automatic int testIndex(input pcT pc);
        for (int t = testCount - 1; t > 0; t--) begin
            if (pc >= testStart[t]) begin
                return t;
            end
        end
        return 0;
    endfunction

    `include "isaModel.svh"

    // ##################################################
    // Program image
    // ##################################################
    task automatic loadProgram();
        logic [2:0] brF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        regAddrT    pairA [3] = '{5'd20, 5'd21, 5'd20};
        regAddrT    pairB [3] = '{5'd21, 5'd20, 5'd20};
        logic [2:0] f3;
        int         imm;
        regAddrT    rd;
        regAddrT    rs1;
        regAddrT    rs2;
        for (int i = 0; i < 4096; i++) begin
            imem[i] = (wordT'(i) << 7) | 32'h0000_000b; // Custom-0 opcode, runs as a no-op
        end
        progLen = 0;
        testStart[0] = '0;
        putInstr(iType(5, 0, 3'b000, 1, opcAriI));
        putInstr(iType(7, 1, 3'b000, 2, opcAriI));
        putInstr(rType(7'h00, 1, 2, 3'b000, 3));
        putInstr(rType(7'h20, 3, 1, 3'b000, 4));    // Forward on rs2
        putInstr(rType(7'h00, 4, 4, 3'b000, 5));    // Both operands
        putInstr(iType(1, 5, 3'b000, 0, opcAriI));  // Write to x0
        putInstr(rType(7'h00, 5, 0, 3'b000, 6));
        putInstr(uType(20'h12345, 7, opcLui));
        putInstr(iType(-1, 7, 3'b100, 7, opcAriI));
        putInstr(uType(1, 8, opcAuipc));
        testStart[1] = pcT'(progLen * 4);
        putInstr(iType(64, 0, 3'b000, 10, opcAriI));
        putInstr(uType(20'habcde, 11, opcLui));
        putInstr(iType(12'h123, 11, 3'b000, 11, opcAriI));
        putInstr(sType(0, 11, 10));
        putInstr(sType(4, 5, 10));
        putInstr(sType(8, 7, 10));
        putInstr(iType(0, 10, 3'b010, 12, opcLoad));
        putInstr(rType(7'h00, 1, 12, 3'b000, 13));
        putInstr(iType(4, 10, 3'b010, 14, opcLoad));
        putInstr(rType(7'h20, 14, 1, 3'b000, 15));
        putInstr(iType(8, 10, 3'b010, 16, opcLoad));
        putInstr(sType(12, 16, 10));                // Store data straight from a load
        putInstr(iType(12, 10, 3'b010, 17, opcLoad));
        putInstr(bType(8, 16, 17, 3'b000));
        putInstr(iType(99, 0, 3'b000, 18, opcAriI));
        putInstr(iType(1, 17, 3'b000, 19, opcAriI));
        testStart[2] = pcT'(progLen * 4);
        putInstr(iType(-3, 0, 3'b000, 20, opcAriI));
        putInstr(iType(4, 0, 3'b000, 21, opcAriI));
        // Three operand orders give each condition both outcomes
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                putInstr(bType(8, pairB[p], pairA[p], brF3[k]));
                putInstr(iType(1, 22, 3'b000, 22, opcAriI));
            end
        end
        testStart[3] = pcT'(progLen * 4);
        putInstr(jType(8, 24));
        putInstr(iType(1, 0, 3'b000, 25, opcAriI));
        putInstr(uType(0, 26, opcAuipc));
        putInstr(iType(13, 26, 3'b000, 27, opcJalr)); // Odd target
        putInstr(iType(2, 0, 3'b000, 25, opcAriI));
        putInstr(iType(0, 27, 3'b000, 28, opcAriI));
        putInstr(jType(8, 0));
        putInstr(iType(3, 0, 3'b000, 25, opcAriI));
        putInstr(iType(4, 24, 3'b000, 29, opcAriI));
        testStart[4] = pcT'(progLen * 4);
        for (int n = 0; n < 40; n++) begin
            f3  = 3'($urandom);
            rd  = regAddrT'(1 + $urandom % 7);
            rs1 = regAddrT'(1 + $urandom % 7);
            rs2 = regAddrT'(1 + $urandom % 7);
            imm = int'($urandom % 4096);
            if (imm % 2 == 0) begin
                if (f3 == 3'b001) begin
                    imm = imm % 32;
                end else if (f3 == 3'b101) begin
                    imm = imm & 32'h41f;            // Bit 10 selects SRAI
                end
                putInstr(iType(imm, rs1, f3, rd, opcAriI));
            end else begin
                putInstr(rType(((f3 == 3'b000 || f3 == 3'b101) && imm[1]) ? 7'h20 : 7'h00,
                               rs2, rs1, f3, rd));
            end
        end
        endPc = pcT'(progLen * 4);
        putInstr(jType(0, 0));                      // Parks the fetch
    endtask

    // ##################################################
    // Retire checking
    // ##################################################
    task automatic reportMismatch(input retireT act, input retireT exp, input int idx);
        int t;
        t = (idx < expTotal) ? testIndex(exp.pc) : testCount - 1;
        errorCount++;
        testErrors[t]++;
        if (idx >= expTotal) begin
            $display("Unexpected register write at pc %h to x%0d after the expected stream ended",
                     act.pc, act.rd);
        end else begin
            $display("ERROR %s: expected pc %h x%0d = %h, actual pc %h x%0d = %h", testNames[t],
                     exp.pc, exp.rd, exp.data, act.pc, act.rd, act.data);
        end
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            expIdx  <= 0;
            expHead <= expList[0];
        end else if (retire.valid) begin
            expIdx  <= expIdx + 1;
            expHead <= expList[expIdx + 1];
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        retire.valid |-> (expIdx < expTotal) && (retire == expHead))
    else reportMismatch($sampled(retire), $sampled(expHead), $sampled(expIdx));

    // A test is done once its last expected write has retired
    always @(negedge clk) begin
        if (rstN && (curTest < testCount) && (expIdx >= expEnd[curTest])) begin
            if (testErrors[curTest] == 0) begin
                $display("PASS %s", testNames[curTest]);
                passCount++;
            end else begin
                $display("FAIL %s with %0d mismatches", testNames[curTest], testErrors[curTest]);
                failCount++;
            end
            curTest++;
        end
    end

    always @(posedge clk) begin
        if (rstN) begin
            cycleCount <= cycleCount + 1;
            if (cycleCount >= cycleLimit) begin
                $display("Timeout after %0d cycles with %0d of %0d expected writes retired",
                         cycleCount, expIdx, expTotal);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    initial begin
        rstN = 1'b0;
        void'($urandom(32'hfec4_173b));
        loadProgram();
        buildExpected();
        cycleLimit = progLen * 3 + 200;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        wait (curTest == testCount);
        $display("Tests passed %0d, failed %0d, mismatches %0d", passCount, failCount, errorCount);
        if ((failCount == 0) && (errorCount == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+test
hw/rvPipePkg.sv
hw/hazardUnit.sv
hw/instDecoder.sv
hw/aluUnit.sv
hw/regFile.sv
hw/dataRam.sv
hw/pipeCore.sv
test/tbPipeCore.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f filelist.f --top-module tbPipeCore \
    -o simPipeCore > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simPipeCore > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
